/* verilog/npu_cfg_pkg.sv */
// Array sizes, operand and register widths
// Register map offsets and buffer windows
// Version constant

package npu_cfg_pkg;

    // Array and operand sizes
    localparam int pe_cols   = 4;
    localparam int data_w    = 8;
    localparam int acc_w     = 32;
    localparam int vec_depth = 8;
    localparam int idx_w     = 3;

    // Host register port
    localparam int reg_addr_w = 8;
    localparam int reg_data_w = 32;

    // Fixed registers
    localparam logic [reg_addr_w-1:0] reg_ctrl       = 8'h00;
    localparam logic [reg_addr_w-1:0] reg_status     = 8'h04;
    localparam logic [reg_addr_w-1:0] reg_irq_en     = 8'h08;
    localparam logic [reg_addr_w-1:0] reg_irq_status = 8'h0C;
    localparam logic [reg_addr_w-1:0] reg_version    = 8'h10;
    localparam logic [reg_addr_w-1:0] reg_config     = 8'h14;
    localparam logic [reg_addr_w-1:0] reg_len        = 8'h18;

    // Windows, one word per step or per column
    localparam logic [reg_addr_w-1:0] act_base = 8'h40;
    localparam logic [reg_addr_w-1:0] wgt_base = 8'h80;
    localparam logic [reg_addr_w-1:0] res_base = 8'hC0;

    localparam logic [reg_data_w-1:0] npu_version = 32'h0001_0400;

endpackage

/* verilog/npu_ctrl_pkg.sv */
// Controller state and activation function encodings

package npu_ctrl_pkg;

    typedef enum logic [3:0] {
        st_idle  = 4'd0,
        st_clear = 4'd1,
        st_mac   = 4'd2,
        st_store = 4'd3,
        st_done  = 4'd4
    } ctrl_state_e;

    // Codes 2 and 3 behave as act_none
    typedef enum logic [1:0] {
        act_none = 2'd0,
        act_relu = 2'd1
    } act_func_e;

endpackage

/* verilog/npu_step_if.sv */
// Per-step control from the FSM and step counter to the datapath

interface npu_step_if;

    // Accumulator clear, one cycle at the start of a run
    logic clear_acc;
    // One operand pair per cycle while high
    logic mac_en;
    // Latch activated sums into the result registers
    logic store;
    // Operand index within the vector
    logic [npu_cfg_pkg::idx_w-1:0] k_index;

    modport fsm (
        output clear_acc,
        output mac_en,
        output store
    );

    modport counter (
        input  clear_acc,
        input  mac_en,
        output k_index
    );

    modport datapath (
        input clear_acc,
        input mac_en,
        input store,
        input k_index
    );

endinterface

/* verilog/npu_reg_file.sv */
// Host register decode, control, length and irq registers
// Buffer write strobes, start pulse, read mux and irq output

module npu_reg_file (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  reg_wr,
    input  logic [npu_cfg_pkg::reg_addr_w-1:0]    reg_addr,
    input  logic [npu_cfg_pkg::reg_data_w-1:0]    reg_wdata,
    output logic [npu_cfg_pkg::reg_data_w-1:0]    reg_rdata,
    output logic                                  irq,
    input  logic                                  busy,
    input  logic                                  done,
    input  npu_ctrl_pkg::ctrl_state_e             state,
    input  logic [npu_cfg_pkg::pe_cols-1:0][npu_cfg_pkg::acc_w-1:0] results,
    output logic                                  start,
    output logic [npu_cfg_pkg::idx_w-1:0]         k_last,
    output npu_ctrl_pkg::act_func_e               act_func,
    output logic                                  act_wr,
    output logic                                  wgt_wr,
    output logic [npu_cfg_pkg::idx_w-1:0]         wr_index,
    output logic [npu_cfg_pkg::reg_data_w-1:0]    wr_data
);

    // ctrl bits: 0 enable, 1 start, 3:2 activation function
    logic [3:0]                    ctrl_q;
    logic                          irq_en_q;
    logic [npu_cfg_pkg::idx_w-1:0] len_q;
    logic                          done_q;
    logic                          irq_st_q;
    logic                          act_hit;
    logic                          wgt_hit;
    logic                          res_hit;

    // =========================================================================
    // Address decode
    // =========================================================================

    // Operand windows span vec_depth words, result window pe_cols words
    assign act_hit = (reg_addr >> (npu_cfg_pkg::idx_w + 2)) ==
                     (npu_cfg_pkg::act_base >> (npu_cfg_pkg::idx_w + 2));
    assign wgt_hit = (reg_addr >> (npu_cfg_pkg::idx_w + 2)) ==
                     (npu_cfg_pkg::wgt_base >> (npu_cfg_pkg::idx_w + 2));
    assign res_hit = (reg_addr >> 4) == (npu_cfg_pkg::res_base >> 4);

    // Buffers stay frozen for the whole run
    assign act_wr   = reg_wr && act_hit && !busy;
    assign wgt_wr   = reg_wr && wgt_hit && !busy;
    assign wr_index = reg_addr[npu_cfg_pkg::idx_w+1:2];
    assign wr_data  = reg_wdata;

    // =========================================================================
    // Control registers
    // =========================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl_q   <= '0;
            irq_en_q <= 1'b0;
            len_q    <= '0;
        end else begin
            // Start bit lives for one cycle unless rewritten
            if (reg_wr && reg_addr == npu_cfg_pkg::reg_ctrl)
                ctrl_q <= reg_wdata[3:0];
            else if (ctrl_q[1])
                ctrl_q[1] <= 1'b0;
            if (reg_wr && reg_addr == npu_cfg_pkg::reg_irq_en)
                irq_en_q <= reg_wdata[0];
            if (reg_wr && reg_addr == npu_cfg_pkg::reg_len)
                len_q <= reg_wdata[npu_cfg_pkg::idx_w-1:0];
        end
    end

    assign start    = ctrl_q[1] && ctrl_q[0];
    assign k_last   = len_q;
    assign act_func = npu_ctrl_pkg::act_func_e'(ctrl_q[3:2]);

    // Sticky done and run-done interrupt status
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done_q   <= 1'b0;
            irq_st_q <= 1'b0;
        end else begin
            if (start)
                done_q <= 1'b0;
            else if (done)
                done_q <= 1'b1;
            // A new done event beats a clear in the same cycle
            if (done)
                irq_st_q <= 1'b1;
            else if (reg_wr && reg_addr == npu_cfg_pkg::reg_irq_status && reg_wdata[0])
                irq_st_q <= 1'b0;
        end
    end

    assign irq = irq_st_q && irq_en_q;

    // =========================================================================
    // Read mux
    // =========================================================================

    always_comb begin
        reg_rdata = '0;
        case (reg_addr)
            npu_cfg_pkg::reg_ctrl:       reg_rdata = npu_cfg_pkg::reg_data_w'(ctrl_q);
            npu_cfg_pkg::reg_status:
                reg_rdata = npu_cfg_pkg::reg_data_w'({state, 2'b00, done_q, busy});
            npu_cfg_pkg::reg_irq_en:     reg_rdata = npu_cfg_pkg::reg_data_w'(irq_en_q);
            npu_cfg_pkg::reg_irq_status: reg_rdata = npu_cfg_pkg::reg_data_w'(irq_st_q);
            npu_cfg_pkg::reg_version:    reg_rdata = npu_cfg_pkg::npu_version;
            npu_cfg_pkg::reg_config:
                reg_rdata = {16'(npu_cfg_pkg::pe_cols), 16'(npu_cfg_pkg::vec_depth)};
            npu_cfg_pkg::reg_len:        reg_rdata = npu_cfg_pkg::reg_data_w'(len_q);
            default: begin
                // Operand windows are write only
                if (res_hit)
                    reg_rdata = results[reg_addr[3:2]];
            end
        endcase
    end

endmodule

/* verilog/npu_controller.sv */
// Run sequencing FSM: idle, clear, mac, store, done
// Busy, done pulse and per-step datapath control

module npu_controller (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start,
    input  logic                      last,
    output logic                      busy,
    output logic                      done,
    output npu_ctrl_pkg::ctrl_state_e state,
    npu_step_if.fsm                   step
);

    npu_ctrl_pkg::ctrl_state_e state_d;

    always_comb begin
        state_d = state;
        case (state)
            npu_ctrl_pkg::st_idle:
                if (start)
                    state_d = npu_ctrl_pkg::st_clear;
            npu_ctrl_pkg::st_clear:
                state_d = npu_ctrl_pkg::st_mac;
            // One operand pair per cycle until the last index
            npu_ctrl_pkg::st_mac:
                if (last)
                    state_d = npu_ctrl_pkg::st_store;
            npu_ctrl_pkg::st_store:
                state_d = npu_ctrl_pkg::st_done;
            default:
                state_d = npu_ctrl_pkg::st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            state <= npu_ctrl_pkg::st_idle;
        else
            state <= state_d;
    end

    // Step control decoded from the state register
    assign step.clear_acc = (state == npu_ctrl_pkg::st_clear);
    assign step.mac_en    = (state == npu_ctrl_pkg::st_mac);
    assign step.store     = (state == npu_ctrl_pkg::st_store);

    assign busy = (state == npu_ctrl_pkg::st_clear) ||
                  (state == npu_ctrl_pkg::st_mac)   ||
                  (state == npu_ctrl_pkg::st_store);
    assign done = (state == npu_ctrl_pkg::st_done);

endmodule

/* verilog/npu_step_counter.sv */
// Operand index counter for the mac phase
// Last-step flag against the programmed length

module npu_step_counter (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [npu_cfg_pkg::idx_w-1:0] k_last,
    npu_step_if.counter                   step,
    output logic                          last
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            step.k_index <= '0;
        else if (step.clear_acc)
            step.k_index <= '0;
        else if (step.mac_en)
            step.k_index <= step.k_index + 1'b1;
    end

    // Only sampled by the FSM during mac
    assign last = (step.k_index == k_last);

endmodule

/* verilog/npu_operand_buffer.sv */
// Activation and weight storage, one entry per step
// Host writes by index, datapath reads at k_index

module npu_operand_buffer (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  act_wr,
    input  logic                                  wgt_wr,
    input  logic [npu_cfg_pkg::idx_w-1:0]         wr_index,
    input  logic [npu_cfg_pkg::reg_data_w-1:0]    wr_data,
    npu_step_if.datapath                          step,
    output logic signed [npu_cfg_pkg::data_w-1:0] act_val,
    output logic [npu_cfg_pkg::pe_cols-1:0][npu_cfg_pkg::data_w-1:0] wgt_vals
);

    logic signed [npu_cfg_pkg::data_w-1:0] act_mem [npu_cfg_pkg::vec_depth];
    // Column c weight in byte c of each word
    logic [npu_cfg_pkg::pe_cols-1:0][npu_cfg_pkg::data_w-1:0]
        wgt_mem [npu_cfg_pkg::vec_depth];

    // Unwritten entries read as zero after reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < npu_cfg_pkg::vec_depth; i++) begin
                act_mem[i] <= '0;
                wgt_mem[i] <= '0;
            end
        end else begin
            if (act_wr)
                act_mem[wr_index] <= wr_data[npu_cfg_pkg::data_w-1:0];
            if (wgt_wr)
                wgt_mem[wr_index] <= wr_data[npu_cfg_pkg::pe_cols*npu_cfg_pkg::data_w-1:0];
        end
    end

    assign act_val  = act_mem[step.k_index];
    assign wgt_vals = wgt_mem[step.k_index];

endmodule

/* verilog/npu_mac_row.sv */
// Row of four signed multiply-accumulate cells
// Activation step and result registers

module npu_mac_row (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic signed [npu_cfg_pkg::data_w-1:0] act_val,
    input  logic [npu_cfg_pkg::pe_cols-1:0][npu_cfg_pkg::data_w-1:0] wgt_vals,
    input  npu_ctrl_pkg::act_func_e               act_func,
    npu_step_if.datapath                          step,
    output logic [npu_cfg_pkg::pe_cols-1:0][npu_cfg_pkg::acc_w-1:0] results
);

    logic signed [npu_cfg_pkg::acc_w-1:0] acc_q [npu_cfg_pkg::pe_cols];
    logic                                 relu_en;

    // Codes other than act_relu pass the sum through
    assign relu_en = (act_func == npu_ctrl_pkg::act_relu);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int c = 0; c < npu_cfg_pkg::pe_cols; c++)
                acc_q[c] <= '0;
            results <= '0;
        end else begin
            for (int c = 0; c < npu_cfg_pkg::pe_cols; c++) begin
                // Product sign-extends to the accumulator width
                if (step.clear_acc)
                    acc_q[c] <= '0;
                else if (step.mac_en)
                    acc_q[c] <= acc_q[c] + act_val * $signed(wgt_vals[c]);

                // Results hold until the next store
                if (step.store) begin
                    if (relu_en && acc_q[c] < 0)
                        results[c] <= '0;
                    else
                        results[c] <= acc_q[c];
                end
            end
        end
    end

endmodule

/* verilog/npu_top.sv */
// NPU compute core top level with a plain host register port
// Register file, controller, step counter, operand buffer, mac row

module npu_top (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               reg_wr,
    input  logic [npu_cfg_pkg::reg_addr_w-1:0] reg_addr,
    input  logic [npu_cfg_pkg::reg_data_w-1:0] reg_wdata,
    output logic [npu_cfg_pkg::reg_data_w-1:0] reg_rdata,
    output logic                               irq
);

    logic                                  start;
    logic                                  busy;
    logic                                  done;
    logic                                  last;
    npu_ctrl_pkg::ctrl_state_e             state;
    npu_ctrl_pkg::act_func_e               act_func;
    logic [npu_cfg_pkg::idx_w-1:0]         k_last;
    logic                                  act_wr;
    logic                                  wgt_wr;
    logic [npu_cfg_pkg::idx_w-1:0]         wr_index;
    logic [npu_cfg_pkg::reg_data_w-1:0]    wr_data;
    logic signed [npu_cfg_pkg::data_w-1:0] act_val;
    logic [npu_cfg_pkg::pe_cols-1:0][npu_cfg_pkg::data_w-1:0] wgt_vals;
    logic [npu_cfg_pkg::pe_cols-1:0][npu_cfg_pkg::acc_w-1:0]  results;

    npu_step_if step_if ();

    // =========================================================================
    // Host side and control
    // =========================================================================

    npu_reg_file u_reg_file (
        .clk       (clk),
        .rst_n     (rst_n),
        .reg_wr    (reg_wr),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .reg_rdata (reg_rdata),
        .irq       (irq),
        .busy      (busy),
        .done      (done),
        .state     (state),
        .results   (results),
        .start     (start),
        .k_last    (k_last),
        .act_func  (act_func),
        .act_wr    (act_wr),
        .wgt_wr    (wgt_wr),
        .wr_index  (wr_index),
        .wr_data   (wr_data)
    );

    npu_controller u_controller (
        .clk   (clk),
        .rst_n (rst_n),
        .start (start),
        .last  (last),
        .busy  (busy),
        .done  (done),
        .state (state),
        .step  (step_if.fsm)
    );

    npu_step_counter u_step_counter (
        .clk    (clk),
        .rst_n  (rst_n),
        .k_last (k_last),
        .step   (step_if.counter),
        .last   (last)
    );

    // =========================================================================
    // Datapath
    // =========================================================================

    npu_operand_buffer u_operand_buffer (
        .clk      (clk),
        .rst_n    (rst_n),
        .act_wr   (act_wr),
        .wgt_wr   (wgt_wr),
        .wr_index (wr_index),
        .wr_data  (wr_data),
        .step     (step_if.datapath),
        .act_val  (act_val),
        .wgt_vals (wgt_vals)
    );

    npu_mac_row u_mac_row (
        .clk      (clk),
        .rst_n    (rst_n),
        .act_val  (act_val),
        .wgt_vals (wgt_vals),
        .act_func (act_func),
        .step     (step_if.datapath),
        .results  (results)
    );

endmodule

/* tb/npu_properties.sv */
// Concurrent checks on run control timing and irq gating
// Bound into npu_top

module npu_properties (
    input logic                               clk,
    input logic                               rst_n,
    input logic                               reg_wr,
    input logic [npu_cfg_pkg::reg_addr_w-1:0] reg_addr,
    input logic [npu_cfg_pkg::reg_data_w-1:0] reg_wdata,
    input logic                               busy,
    input logic                               done,
    input logic                               irq,
    input logic                               mac_en
);
    timeunit 1ns;
    timeprecision 1ps;

    // Host view of irq enable and run-done status
    logic irq_en_m;
    logic irq_st_m;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            irq_en_m <= 1'b0;
            irq_st_m <= 1'b0;
        end else begin
            if (reg_wr && reg_addr == npu_cfg_pkg::reg_irq_en)
                irq_en_m <= reg_wdata[0];
            if (done)
                irq_st_m <= 1'b1;
            else if (reg_wr && reg_addr == npu_cfg_pkg::reg_irq_status && reg_wdata[0])
                irq_st_m <= 1'b0;
        end
    end

    done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
        else $error("done stayed high for more than one cycle");

    // Done comes straight after the last busy cycle
    busy_done_apart: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> !busy && $past(busy))
        else $error("done high together with busy or without a run before it");

    // irq only from a pending status bit that is enabled
    irq_gated: assert property (@(posedge clk) disable iff (!rst_n)
        irq |-> (irq_st_m && irq_en_m))
        else $error("irq high without both status and enable bits set");

    // A mac step always follows the clear cycle of a run
    mac_in_run: assert property (@(posedge clk) disable iff (!rst_n)
        mac_en |-> busy && $past(busy))
        else $error("mac_en high outside a busy run");

endmodule

bind npu_top npu_properties props0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .reg_wr    (reg_wr),
    .reg_addr  (reg_addr),
    .reg_wdata (reg_wdata),
    .busy      (busy),
    .done      (done),
    .irq       (irq),
    .mac_en    (step_if.mac_en)
);

/* tb/tb_npu.sv */
// Testbench for npu_top with clock, reset and register tasks
// Random operands checked against a dot product model

module tb_npu;
    timeunit 1ns;
    timeprecision 1ps;

    logic                               clk;
    logic                               rst_n;
    logic                               reg_wr;
    logic [npu_cfg_pkg::reg_addr_w-1:0] reg_addr;
    logic [npu_cfg_pkg::reg_data_w-1:0] reg_wdata;
    logic [npu_cfg_pkg::reg_data_w-1:0] reg_rdata;
    logic                               irq;

    int value_errors;
    int timeout_errors;

    // Model copies of the operand buffers and length
    logic signed [7:0] act_m [8];
    logic signed [7:0] wgt_m [8][4];
    int                len_m;

    npu_top dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .reg_wr    (reg_wr),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .reg_rdata (reg_rdata),
        .irq       (irq)
    );

    always #5 clk = ~clk;

    // ========================================================================
    // Register access and model
    // ========================================================================

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
        @(posedge clk);
        #1;
        reg_wr    = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        @(posedge clk);
        #1;
        reg_wr = 1'b0;
    endtask

    // Read data is combinational, sampled well after the edge
    task automatic read_reg(input logic [7:0] addr, output logic [31:0] data);
        @(posedge clk);
        #1;
        reg_addr = addr;
        #1;
        data = reg_rdata;
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (expected === actual) else begin
            $display("FAIL %s expected %h actual %h", name, expected, actual);
            value_errors++;
        end
    endtask

    function automatic logic [31:0] expected_result(input int col, input bit relu);
        int sum;
        sum = 0;
        for (int k = 0; k <= len_m; k++)
            sum += int'(act_m[k]) * int'(wgt_m[k][col]);
        if (relu && sum < 0)
            sum = 0;
        return 32'(sum);
    endfunction

    // Upper bits of activation words are random and must be ignored
    task automatic load_operands(input int len);
        logic [31:0] word;
        len_m = len;
        write_reg(npu_cfg_pkg::reg_len, 32'(len));
        for (int k = 0; k <= len; k++) begin
            word     = $urandom;
            act_m[k] = word[7:0];
            write_reg(npu_cfg_pkg::act_base + 8'(4 * k), word);
            word = $urandom;
            for (int c = 0; c < 4; c++)
                wgt_m[k][c] = word[8*c +: 8];
            write_reg(npu_cfg_pkg::wgt_base + 8'(4 * k), word);
        end
    endtask

    task automatic start_run(input npu_ctrl_pkg::act_func_e func);
        write_reg(npu_cfg_pkg::reg_ctrl, {28'h0, func, 2'b11});
    endtask

    task automatic wait_done();
        logic [31:0] status;
        bit          seen;
        seen = 1'b0;
        for (int n = 0; n < 200 && !seen; n++) begin
            read_reg(npu_cfg_pkg::reg_status, status);
            seen = status[1];
        end
        assert (seen) else begin
            $display("Timeout: done bit in status never set after start");
            timeout_errors++;
        end
    endtask

    task automatic check_results(input string name, input bit relu);
        logic [31:0] actual;
        for (int c = 0; c < npu_cfg_pkg::pe_cols; c++) begin
            read_reg(npu_cfg_pkg::res_base + 8'(4 * c), actual);
            check_value($sformatf("%s col %0d", name, c), expected_result(c, relu), actual);
        end
    endtask

    // ========================================================================
    // Test sequence
    // ========================================================================

    initial begin
        logic [31:0] data;
        logic [31:0] held [npu_cfg_pkg::pe_cols];
        clk            = 1'b0;
        rst_n          = 1'b0;
        reg_wr         = 1'b0;
        reg_addr       = '0;
        reg_wdata      = '0;
        value_errors   = 0;
        timeout_errors = 0;
        len_m          = 0;
        void'($urandom(33226));
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Fixed and reset values
        read_reg(npu_cfg_pkg::reg_version, data);
        check_value("version", npu_cfg_pkg::npu_version, data);
        read_reg(npu_cfg_pkg::reg_config, data);
        check_value("config", 32'h0004_0008, data);
        read_reg(npu_cfg_pkg::reg_status, data);
        check_value("status after reset", 32'h0, data);
        write_reg(npu_cfg_pkg::reg_irq_en, 32'h1);
        read_reg(npu_cfg_pkg::reg_irq_en, data);
        check_value("irq_en readback", 32'h1, data);
        write_reg(npu_cfg_pkg::reg_len, 32'h5);
        read_reg(npu_cfg_pkg::reg_len, data);
        check_value("len readback", 32'h5, data);

        for (int r = 0; r < 20; r++) begin
            load_operands(int'($urandom_range(7, 0)));
            start_run(npu_ctrl_pkg::act_none);
            wait_done();
            check_results($sformatf("dot run %0d", r), 1'b0);
        end

        for (int r = 0; r < 10; r++) begin
            load_operands(int'($urandom_range(7, 0)));
            start_run(npu_ctrl_pkg::act_relu);
            wait_done();
            check_results($sformatf("relu run %0d", r), 1'b1);
        end

        // Interrupt set, clear by writing 1, and masking
        write_reg(npu_cfg_pkg::reg_irq_status, 32'h1);
        check_value("irq after clear", 32'h0, 32'(irq));
        start_run(npu_ctrl_pkg::act_none);
        wait_done();
        check_value("irq after run", 32'h1, 32'(irq));
        read_reg(npu_cfg_pkg::reg_irq_status, data);
        check_value("irq_status after run", 32'h1, data);
        write_reg(npu_cfg_pkg::reg_irq_status, 32'h1);
        read_reg(npu_cfg_pkg::reg_irq_status, data);
        check_value("irq_status cleared", 32'h0, data);
        check_value("irq cleared", 32'h0, 32'(irq));
        write_reg(npu_cfg_pkg::reg_irq_en, 32'h0);
        start_run(npu_ctrl_pkg::act_none);
        wait_done();
        check_value("irq masked", 32'h0, 32'(irq));
        read_reg(npu_cfg_pkg::reg_irq_status, data);
        check_value("irq_status masked run", 32'h1, data);
        write_reg(npu_cfg_pkg::reg_irq_status, 32'h1);

        // Start bit without enable must not launch a run
        // New operands would change the results of any run
        for (int c = 0; c < npu_cfg_pkg::pe_cols; c++)
            held[c] = expected_result(c, 1'b0);
        load_operands(int'($urandom_range(7, 0)));
        write_reg(npu_cfg_pkg::reg_ctrl, 32'h2);
        for (int n = 0; n < 12; n++) begin
            read_reg(npu_cfg_pkg::reg_status, data);
            check_value("disabled start busy", 32'h0, 32'(data[0]));
        end
        read_reg(npu_cfg_pkg::reg_ctrl, data);
        check_value("disabled start ctrl", 32'h0, data);
        read_reg(npu_cfg_pkg::reg_irq_status, data);
        check_value("disabled start irq_status", 32'h0, data);
        for (int c = 0; c < npu_cfg_pkg::pe_cols; c++) begin
            read_reg(npu_cfg_pkg::res_base + 8'(4 * c), data);
            check_value($sformatf("disabled start col %0d", c), held[c], data);
        end

        // Buffer writes during a run are dropped
        load_operands(7);
        start_run(npu_ctrl_pkg::act_relu);
        write_reg(npu_cfg_pkg::act_base, $urandom);
        write_reg(npu_cfg_pkg::wgt_base + 8'd28, $urandom);
        read_reg(npu_cfg_pkg::reg_status, data);
        check_value("busy during writes", 32'h1, 32'(data[0]));
        wait_done();
        check_results("busy writes", 1'b1);

        $display("Errors: %0d value, %0d timeout", value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* npu_lite.f */
verilog/npu_cfg_pkg.sv
verilog/npu_ctrl_pkg.sv
verilog/npu_step_if.sv
verilog/npu_reg_file.sv
verilog/npu_controller.sv
verilog/npu_step_counter.sv
verilog/npu_operand_buffer.sv
verilog/npu_mac_row.sv
verilog/npu_top.sv
tb/npu_properties.sv
tb/tb_npu.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_npu -f npu_lite.f

output=$(./obj_dir/Vtb_npu 2>&1) || true
printf '%s\n' "$output"

# The run passes only when the testbench printed its pass line
printf '%s\n' "$output" | grep -qx "sim passed"
